// File: hdl/uart_fifo.sv
/*
 * Synchronous FIFO with a registered head word. Writes while full are
 * dropped and raise the sticky overrun flag. Reads while empty are ignored.
 */
`timescale 1ns/1ps

module uart_fifo
    import uart_link_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     wr_i,
    input  payload_t wr_data_i,
    input  logic     rd_i,
    output payload_t rd_data_o,
    output logic     full_o,
    output logic     empty_o,
    output logic     overrun_o
);

    payload_t                   mem [UART_FIFO_DEPTH];
    logic [UART_FIFO_PTR_W-1:0] wr_ptr;
    logic [UART_FIFO_PTR_W-1:0] rd_ptr;
    logic [UART_FIFO_PTR_W-1:0] rd_ptr_nxt;
    logic [UART_FIFO_PTR_W:0]   count;
    logic                       do_wr;
    logic                       do_rd;

    assign do_wr      = wr_i && !full_o;
    assign do_rd      = rd_i && !empty_o;
    assign rd_ptr_nxt = rd_ptr + UART_FIFO_PTR_W'(do_rd);

    assign empty_o = (count == '0);
    assign full_o  = (count == (UART_FIFO_PTR_W + 1)'(UART_FIFO_DEPTH));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overrun_o <= 1'b0;
        end else begin
            wr_ptr    <= wr_ptr + UART_FIFO_PTR_W'(do_wr);
            rd_ptr    <= rd_ptr_nxt;
            count     <= count + (UART_FIFO_PTR_W + 1)'(do_wr) - (UART_FIFO_PTR_W + 1)'(do_rd);
            overrun_o <= overrun_o || (wr_i && full_o);
        end
    end

    // The head register follows the read pointer. A word written into the
    // slot that becomes the head bypasses the array
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data_i;
        end
        if (do_wr && (wr_ptr == rd_ptr_nxt)) begin
            rd_data_o <= wr_data_i;
        end else begin
            rd_data_o <= mem[rd_ptr_nxt];
        end
    end

endmodule

// File: hdl/uart_frame_pkg.sv
/*
 * Serial frame format for the UART. Only 8N1 is supported, so there is
 * no parity and always a single stop bit.
 */
package uart_frame_pkg;

    // Data bits per frame, sent LSB first
    localparam int unsigned UART_DATA_BITS = 8;

    // Smallest divider for which the receiver still finds the middle of a bit
    localparam int unsigned UART_DIV_MIN = 7;

    localparam int unsigned UART_BIT_IDX_W = $clog2(UART_DATA_BITS);
    localparam logic [UART_BIT_IDX_W-1:0] UART_LAST_BIT = UART_BIT_IDX_W'(UART_DATA_BITS - 1);

    typedef enum logic [1:0] {
        IDLE  = 2'h0,
        START = 2'h1,
        DATA  = 2'h2,
        STOP  = 2'h3
    } uart_tx_state_t;

    // One received byte and the result of its stop-bit check
    typedef struct packed {
        logic                      frame_err;
        logic [UART_DATA_BITS-1:0] data;
    } uart_rx_word_t;

endpackage

// File: hdl/uart_link_pkg.sv
/*
 * Sizing of the host side. The FIFO depth has to be a power of two so
 * that the pointers wrap without extra logic.
 */
package uart_link_pkg;

    // Width of the run-time baud divider
    localparam int unsigned UART_DIV_W = 32;

    // Entries in each of the tx and rx FIFOs
    localparam int unsigned UART_FIFO_DEPTH = 16;

    // Address width that belongs to UART_FIFO_DEPTH
    localparam int unsigned UART_FIFO_PTR_W = 4;

endpackage

// File: hdl/uart_rx.sv
/*
 * 8N1 receiver with mid-bit sampling. The divider must be at least
 * UART_DIV_MIN. A low stop bit is flagged, and the word is still delivered.
 */
`timescale 1ns/1ps

module uart_rx
    import uart_frame_pkg::*;
    import uart_link_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  rx_i,
    input  logic [UART_DIV_W-1:0] baud_div_i,
    output uart_rx_word_t         rx_word_o,
    output logic                  rx_word_vld_o
);

    typedef enum logic [1:0] {
        RX_IDLE  = 2'h0,
        RX_START = 2'h1,
        RX_DATA  = 2'h2,
        RX_STOP  = 2'h3
    } rx_state_t;

    rx_state_t                 state;
    logic                      rx_meta;
    logic                      rx_sync;
    logic                      rx_prev;
    logic                      fall;
    logic [UART_DIV_W-1:0]     baud_cnt;
    logic [UART_DIV_W-1:0]     half_div;
    logic                      half_stb;
    logic                      bit_stb;
    logic [UART_BIT_IDX_W-1:0] bit_idx;
    logic [UART_DATA_BITS-1:0] shift_q;

    ////////////////////////////////////////////////////////////////////////////
    // Input synchronizer and start edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // A real high to low edge is needed, so a line stuck low after a bad
    // stop bit does not start another frame
    assign fall = rx_prev && !rx_sync;

    ////////////////////////////////////////////////////////////////////////////
    // Sample timing
    ////////////////////////////////////////////////////////////////////////////

    assign half_div = baud_div_i >> 1;
    assign half_stb = (state == RX_START) && (baud_cnt == half_div);
    assign bit_stb  = ((state == RX_DATA) || (state == RX_STOP)) && (baud_cnt == baud_div_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_cnt <= '0;
        end else if ((state == RX_IDLE) || half_stb || bit_stb) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state         <= RX_IDLE;
            bit_idx       <= '0;
            rx_word_vld_o <= 1'b0;
        end else begin
            rx_word_vld_o <= (state == RX_STOP) && bit_stb;
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Line back high at mid start bit means it was a glitch
                    if (half_stb) begin
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                        bit_idx <= '0;
                    end
                end
                RX_DATA: begin
                    if (bit_stb) begin
                        if (bit_idx == UART_LAST_BIT) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_stb) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Bits arrive LSB first and enter at the top of the shifter
    always_ff @(posedge clk_i) begin
        if ((state == RX_DATA) && bit_stb) begin
            shift_q <= {rx_sync, shift_q[UART_DATA_BITS-1:1]};
        end
        if ((state == RX_STOP) && bit_stb) begin
            rx_word_o.data      <= shift_q;
            rx_word_o.frame_err <= !rx_sync;
        end
    end

endmodule

// File: hdl/uart_top.sv
/*
 * UART with a transmit and a receive FIFO. The host must not write while
 * tx_full_o is high. Received words that find the rx FIFO full are lost.
 */
`timescale 1ns/1ps

module uart_top
    import uart_frame_pkg::*;
    import uart_link_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [UART_DIV_W-1:0]     baud_div_i,
    input  logic                      tx_wr_i,
    input  logic [UART_DATA_BITS-1:0] tx_data_i,
    input  logic                      rx_i,
    input  logic                      rx_rd_i,
    output logic                      tx_o,
    output logic                      tx_full_o,
    output logic                      rx_empty_o,
    output logic [UART_DATA_BITS-1:0] rx_data_o,
    output logic                      rx_frame_err_o,
    output logic                      rx_overrun_o
);

    logic [UART_DATA_BITS-1:0] tx_head;
    logic                      tx_empty;
    logic                      tx_fifo_vld;
    logic                      tx_ack;
    uart_rx_word_t             rx_word;
    logic                      rx_word_vld;
    uart_rx_word_t             rx_head;

    ////////////////////////////////////////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////////////////////////////////////////

    uart_fifo #(
        .payload_t (logic [UART_DATA_BITS-1:0])
    ) u_tx_fifo (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_i      (tx_wr_i),
        .wr_data_i (tx_data_i),
        .rd_i      (tx_ack),
        .rd_data_o (tx_head),
        .full_o    (tx_full_o),
        .empty_o   (tx_empty),
        .overrun_o ()
    );

    assign tx_fifo_vld = !tx_empty;

    uart_tx u_tx (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .tx_data_i     (tx_head),
        .tx_data_vld_i (tx_fifo_vld),
        .baud_div_i    (baud_div_i),
        .tx_o          (tx_o),
        .tx_ack_o      (tx_ack)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////////////////////

    uart_rx u_rx (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rx_i          (rx_i),
        .baud_div_i    (baud_div_i),
        .rx_word_o     (rx_word),
        .rx_word_vld_o (rx_word_vld)
    );

    uart_fifo #(
        .payload_t (uart_rx_word_t)
    ) u_rx_fifo (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wr_i      (rx_word_vld),
        .wr_data_i (rx_word),
        .rd_i      (rx_rd_i),
        .rd_data_o (rx_head),
        .full_o    (),
        .empty_o   (rx_empty_o),
        .overrun_o (rx_overrun_o)
    );

    assign rx_data_o      = rx_head.data;
    assign rx_frame_err_o = rx_head.frame_err;

endmodule

// File: hdl/uart_tx.sv
/*
 * 8N1 transmitter. A bit lasts baud_div_i + 1 clocks and the divider must not
 * change during a frame. A waiting byte is taken at the end of the stop bit.
 */
`timescale 1ns/1ps

module uart_tx
    import uart_frame_pkg::*;
    import uart_link_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [UART_DATA_BITS-1:0] tx_data_i,
    input  logic                      tx_data_vld_i,
    input  logic [UART_DIV_W-1:0]     baud_div_i,
    output logic                      tx_o,
    output logic                      tx_ack_o
);

    uart_tx_state_t            state;
    logic [UART_DIV_W-1:0]     baud_cnt;
    logic                      bit_stb;
    logic                      capture;
    logic [UART_BIT_IDX_W-1:0] bit_idx;
    logic [UART_DATA_BITS-1:0] shift_q;

    ////////////////////////////////////////////////////////////////////////////
    // Baud timing
    ////////////////////////////////////////////////////////////////////////////

    // Strobe on the last clock of every bit period
    assign bit_stb = (state != IDLE) && (baud_cnt == baud_div_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            baud_cnt <= '0;
        end else if ((state == IDLE) || bit_stb) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencing
    ////////////////////////////////////////////////////////////////////////////

    // A byte is taken when idle, or at the end of STOP so frames run back to back
    assign capture  = tx_data_vld_i && ((state == IDLE) || ((state == STOP) && bit_stb));
    assign tx_ack_o = capture;

    // The line register changes on the same edge as the state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= IDLE;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (capture) begin
                        state <= START;
                        tx_o  <= 1'b0;
                    end
                end
                START: begin
                    if (bit_stb) begin
                        state   <= DATA;
                        bit_idx <= '0;
                        tx_o    <= shift_q[0];
                    end
                end
                DATA: begin
                    if (bit_stb) begin
                        if (bit_idx == UART_LAST_BIT) begin
                            state <= STOP;
                            tx_o  <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_o    <= shift_q[1];
                        end
                    end
                end
                STOP: begin
                    if (capture) begin
                        state <= START;
                        tx_o  <= 1'b0;
                    end else if (bit_stb) begin
                        state <= IDLE;
                        tx_o  <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    tx_o  <= 1'b1;
                end
            endcase
        end
    end

    // Bit 0 of the shifter is always the bit now on the line
    always_ff @(posedge clk_i) begin
        if (capture) begin
            shift_q <= tx_data_i;
        end else if ((state == DATA) && bit_stb) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module uart_tb \
    -o uart_sim > build.log 2>&1 &&
./obj_dir/uart_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "Test passed" sim.log ||
{ echo "simulation did not pass, see sim.log"; exit 1; }
echo "simulation finished successfully"

// File: sim.f
hdl/uart_frame_pkg.sv
hdl/uart_link_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
sim/uart_asserts.sv
sim/uart_tb.sv

// File: sim/uart_asserts.sv
/*
 * Assertions bound into every uart_tx and uart_fifo instance. Inputs that
 * do not apply to an instance are tied to harmless constants.
 */
`timescale 1ns/1ps

module uart_asserts
    import uart_frame_pkg::*;
(
    input logic           clk_i,
    input logic           rst_n_i,
    input uart_tx_state_t state_i,
    input logic           tx_i,
    input logic           ack_i,
    input logic           full_i,
    input logic           empty_i
);

    // The line rests high between frames
    a_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == IDLE) |-> tx_i)
        else $error("tx line low while the transmitter is idle");

    a_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(full_i && empty_i))
        else $error("FIFO reports full and empty together");

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else $error("tx accept pulse longer than one cycle");

endmodule

bind uart_tx uart_asserts u_tx_asserts (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .state_i (state), .tx_i (tx_o),
    .ack_i (tx_ack_o), .full_i (1'b0), .empty_i (1'b1)
);

bind uart_fifo uart_asserts u_fifo_asserts (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .state_i (uart_frame_pkg::IDLE), .tx_i (1'b1),
    .ack_i (1'b0), .full_i (full_o), .empty_i (empty_o)
);

// File: sim/uart_tb.sv
/*
 * Testbench for uart_top. Loopback runs tx_o into rx_i unless the line
 * override selects the testbench-driven line. Stops at the first mismatch.
 */
`timescale 1ns/1ps

module uart_tb
    import uart_frame_pkg::*;
    import uart_link_pkg::*;
;

    localparam int NUM_ROWS = 5;

    // One stimulus row: divider, frame count, injected mode and stop level
    typedef struct packed {
        logic [31:0] div;
        logic [7:0]  nbytes;
        logic        injected;
        logic        stop_bit;
    } row_t;

    logic                      clk_i = 1'b0;
    logic                      rst_n_i;
    logic [UART_DIV_W-1:0]     baud_div_i;
    logic                      tx_wr_i;
    logic [UART_DATA_BITS-1:0] tx_data_i;
    logic                      rx_i;
    logic                      rx_rd_i;
    logic                      tx_o;
    logic                      tx_full_o;
    logic                      rx_empty_o;
    logic [UART_DATA_BITS-1:0] rx_data_o;
    logic                      rx_frame_err_o;
    logic                      rx_overrun_o;

    logic                      line_override;
    logic                      line_drv;
    row_t                      rows [NUM_ROWS];
    logic [UART_DATA_BITS-1:0] exp_q [$];
    int unsigned               cycle_cnt = 0;
    int unsigned               cycle_limit = 0;

    assign rx_i = line_override ? line_drv : tx_o;

    uart_top DUT (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .baud_div_i     (baud_div_i),
        .tx_wr_i        (tx_wr_i),
        .tx_data_i      (tx_data_i),
        .rx_i           (rx_i),
        .rx_rd_i        (rx_rd_i),
        .tx_o           (tx_o),
        .tx_full_o      (tx_full_o),
        .rx_empty_o     (rx_empty_o),
        .rx_data_o      (rx_data_o),
        .rx_frame_err_o (rx_frame_err_o),
        .rx_overrun_o   (rx_overrun_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if ((cycle_limit != 0) && (cycle_cnt > cycle_limit)) begin
            stop_with_failure("timeout, the DUT did not finish within the cycle limit");
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input string name, input logic [UART_DATA_BITS-1:0] got, exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input uart_rx_word_t got, exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic write_byte(input logic [UART_DATA_BITS-1:0] b);
        @(negedge clk_i);
        while (tx_full_o) @(negedge clk_i);
        @(posedge clk_i);
        tx_wr_i   <= 1'b1;
        tx_data_i <= b;
        @(posedge clk_i);
        tx_wr_i <= 1'b0;
    endtask

    // Head of the rx FIFO is taken at a falling edge, then popped
    task automatic read_word(output uart_rx_word_t w);
        @(negedge clk_i);
        while (rx_empty_o) @(negedge clk_i);
        w.frame_err = rx_frame_err_o;
        w.data      = rx_data_o;
        @(posedge clk_i);
        rx_rd_i <= 1'b1;
        @(posedge clk_i);
        rx_rd_i <= 1'b0;
    endtask

    task automatic send_frame(input logic [UART_DATA_BITS-1:0] b, input logic stop_bit,
                              input int unsigned period);
        @(posedge clk_i);
        line_drv <= 1'b0;
        repeat (period) @(posedge clk_i);
        for (int i = 0; i < UART_DATA_BITS; i++) begin
            line_drv <= b[i];
            repeat (period) @(posedge clk_i);
        end
        line_drv <= stop_bit;
        repeat (period) @(posedge clk_i);
        line_drv <= 1'b1;
        repeat (period) @(posedge clk_i);
    endtask

    task automatic set_mode(input logic [31:0] div, input logic injected);
        @(posedge clk_i);
        baud_div_i    <= div;
        line_override <= injected;
        line_drv      <= 1'b1;
    endtask

    initial begin
        int unsigned   rnd;
        uart_rx_word_t got_w;
        uart_rx_word_t exp_w;
        logic          exp_bit;

        void'($urandom(32'he7d5387b));
        rst_n_i       = 1'b0;
        baud_div_i    = UART_DIV_MIN;
        tx_wr_i       = 1'b0;
        tx_data_i     = '0;
        rx_rd_i       = 1'b0;
        line_override = 1'b0;
        line_drv      = 1'b1;
        rows[0] = '{UART_DIV_MIN, 8'd8, 1'b0, 1'b1};
        rows[1] = '{32'd15, 8'd6, 1'b0, 1'b1};
        rows[2] = '{32'd24, 8'd5, 1'b0, 1'b1};
        rows[3] = '{32'd10, 8'd3, 1'b1, 1'b1};
        rows[4] = '{32'd10, 8'd2, 1'b1, 1'b0};

        // Frames times bit period for the table, then the timing, streaming
        // and overrun steps
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += int'(rows[r].nbytes) * 10 * (rows[r].div + 1);
        end
        cycle_limit += 1 * 10 * 10 + (UART_FIFO_DEPTH + 2) * 10 * (UART_DIV_MIN + 1);
        cycle_limit += (UART_FIFO_DEPTH + 1) * 10 * 11 + 2000;

        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_flag("tx_o", tx_o, 1'b1);
        check_flag("rx_empty_o", rx_empty_o, 1'b1);
        check_flag("tx_full_o", tx_full_o, 1'b0);
        check_flag("rx_overrun_o", rx_overrun_o, 1'b0);

        ////////////////////////////////////////////////////////////////////////////
        // Table rows: loopback and injected frames
        ////////////////////////////////////////////////////////////////////////////
        for (int r = 0; r < NUM_ROWS; r++) begin
            set_mode(rows[r].div, rows[r].injected);
            for (int b = 0; b < int'(rows[r].nbytes); b++) begin
                rnd = $urandom;
                exp_q.push_back(rnd[7:0]);
                if (rows[r].injected) begin
                    send_frame(rnd[7:0], rows[r].stop_bit, rows[r].div + 1);
                end else begin
                    write_byte(rnd[7:0]);
                end
            end
            for (int b = 0; b < int'(rows[r].nbytes); b++) begin
                read_word(got_w);
                exp_w.data      = exp_q.pop_front();
                exp_w.frame_err = !rows[r].stop_bit;
                if (rows[r].injected) begin
                    check_word("rx word", got_w, exp_w);
                end else begin
                    check_byte("rx_data_o", got_w.data, exp_w.data);
                    check_flag("rx_frame_err_o", got_w.frame_err, 1'b0);
                end
            end
            repeat (2 * (rows[r].div + 1)) @(posedge clk_i);
        end

        // Single frame timing, with the receiver held on an idle line
        set_mode(32'd9, 1'b1);
        rnd = $urandom;
        @(posedge clk_i);
        tx_wr_i   <= 1'b1;
        tx_data_i <= rnd[7:0];
        @(posedge clk_i);
        tx_wr_i <= 1'b0;
        @(posedge clk_i);
        for (int i = 0; i < 10; i++) begin
            repeat ((i == 0) ? 5 : 10) @(posedge clk_i);
            @(negedge clk_i);
            exp_bit = (i == 0) ? 1'b0 : ((i == 9) ? 1'b1 : rnd[i-1]);
            check_flag($sformatf("tx_o bit %0d", i), tx_o, exp_bit);
        end
        repeat (20) @(posedge clk_i);
        check_flag("rx_empty_o", rx_empty_o, 1'b1);

        // Writes on consecutive cycles, the last one finds the FIFO full
        set_mode(UART_DIV_MIN, 1'b0);
        for (int k = 0; k < UART_FIFO_DEPTH + 2; k++) begin
            rnd = $urandom;
            @(posedge clk_i);
            tx_wr_i   <= 1'b1;
            tx_data_i <= rnd[7:0];
            if (k < UART_FIFO_DEPTH + 1) exp_q.push_back(rnd[7:0]);
        end
        @(posedge clk_i);
        tx_wr_i <= 1'b0;
        @(negedge clk_i);
        check_flag("tx_full_o", tx_full_o, 1'b1);
        for (int k = 0; k < UART_FIFO_DEPTH + 1; k++) begin
            read_word(got_w);
            check_byte("rx_data_o", got_w.data, exp_q.pop_front());
            check_flag("rx_frame_err_o", got_w.frame_err, 1'b0);
        end
        // A frame from an extra byte would have been received by now
        repeat (12 * (UART_DIV_MIN + 1)) @(posedge clk_i);
        @(negedge clk_i);
        check_flag("rx_empty_o", rx_empty_o, 1'b1);
        check_flag("rx_overrun_o", rx_overrun_o, 1'b0);

        // Receive one frame more than the rx FIFO holds
        set_mode(32'd10, 1'b1);
        for (int k = 0; k < UART_FIFO_DEPTH + 1; k++) begin
            rnd = $urandom;
            if (k < UART_FIFO_DEPTH) exp_q.push_back(rnd[7:0]);
            send_frame(rnd[7:0], 1'b1, 11);
            @(negedge clk_i);
            check_flag("rx_overrun_o", rx_overrun_o, (k == UART_FIFO_DEPTH));
        end
        for (int k = 0; k < UART_FIFO_DEPTH; k++) begin
            read_word(got_w);
            check_byte("rx_data_o", got_w.data, exp_q.pop_front());
        end
        @(negedge clk_i);
        check_flag("rx_empty_o", rx_empty_o, 1'b1);

        $display("Test passed");
        $finish;
    end

endmodule
